/* hw/mem_arbiter.sv */
// arbitrates one memory between the instruction and data ports
// data port wins at idle, a fetch that waited through a data access goes next
// requests are levels held until that port's busy drops for one cycle
// no instruction-side writes, load data is returned as the full word
`timescale 1ns/1ps

module mem_arbiter (
  input  logic               CLK,
  input  logic               nRST,
  input  mem_pkg::iport_req_t i_iport_req,
  input  mem_pkg::dport_req_t i_dport_req,
  input  logic               i_mem_busy,
  input  mem_pkg::word_t     i_mem_rdata,
  output mem_pkg::mem_req_t  o_mem_req,
  output logic               o_iport_busy,
  output logic               o_dport_busy,
  output mem_pkg::word_t     o_iport_rdata,
  output mem_pkg::word_t     o_dport_rdata
);

  import mem_pkg::*;

  arb_state_t state;
  arb_state_t next_state;

  // fetch was held while the data port had the memory
  logic fetch_waited;

  logic  data_req;
  logic  fetch_req;
  logic  data_done;
  logic  instr_done;
  word_t aligned_wdata;

  // request levels from each side
  assign data_req  = i_dport_req.ren | i_dport_req.wen;
  assign fetch_req = i_iport_req.ren;

  // completion is the cycle memory busy is low in the granted state
  assign data_done  = (state == DATA_ACCESS) && !i_mem_busy;
  assign instr_done = (state == INSTR_ACCESS) && !i_mem_busy;

  // state register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // remember a fetch stuck behind a data access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_waited <= 1'b0;
    end else if (instr_done || !fetch_req) begin
      fetch_waited <= 1'b0;
    end else if (state == DATA_ACCESS) begin
      fetch_waited <= 1'b1;
    end
  end

  // next state
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        // a waited fetch keeps its turn over a new data request
        if (fetch_waited && fetch_req) begin
          next_state = INSTR_ACCESS;
        end else if (data_req) begin
          next_state = DATA_ACCESS;
        end else if (fetch_req) begin
          next_state = INSTR_ACCESS;
        end
      end
      DATA_ACCESS: begin
        if (data_done) begin
          // fetch raised this very cycle counts as waiting too
          if (fetch_waited || fetch_req) begin
            next_state = INSTR_ACCESS;
          end else begin
            next_state = IDLE;
          end
        end else if (!data_req) begin
          // requester gave up, nothing left to finish
          next_state = IDLE;
        end
      end
      INSTR_ACCESS: begin
        if (instr_done || !fetch_req) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // store data moved up to the lowest enabled lane
  always_comb begin
    case (i_dport_req.byte_en)
      4'h2:       aligned_wdata = i_dport_req.wdata << 8;
      4'h4, 4'hc: aligned_wdata = i_dport_req.wdata << 16;
      4'h8:       aligned_wdata = i_dport_req.wdata << 24;
      // 1, 3 and f sit on lane 0 already
      default:    aligned_wdata = i_dport_req.wdata;
    endcase
  end

  // memory request from the granted port
  always_comb begin
    o_mem_req = '0;
    case (state)
      DATA_ACCESS: begin
        o_mem_req.ren     = i_dport_req.ren;
        o_mem_req.wen     = i_dport_req.wen;
        o_mem_req.addr    = i_dport_req.addr;
        o_mem_req.wdata   = aligned_wdata;
        o_mem_req.byte_en = i_dport_req.byte_en;
      end
      INSTR_ACCESS: begin
        // fetches read the whole word
        o_mem_req.ren     = i_iport_req.ren;
        o_mem_req.addr    = i_iport_req.addr;
        o_mem_req.byte_en = '1;
      end
      default: begin
        o_mem_req = '0;
      end
    endcase
  end

  // busy reaches only the granted port, the other one waits
  assign o_dport_busy = (state == DATA_ACCESS) ? i_mem_busy : 1'b1;
  assign o_iport_busy = (state == INSTR_ACCESS) ? i_mem_busy : 1'b1;

  // read word shared, only valid where busy is low
  assign o_dport_rdata = i_mem_rdata;
  assign o_iport_rdata = i_mem_rdata;

endmodule

/* hw/mem_pkg.sv */
// shared types and constants for the instruction/data memory front end
// addresses are byte addresses and accesses are word aligned, bits 1:0 ignored
// memory depth and wait states are fixed here for every instance
// byte_en legal values are 1, 2, 4, 8, 3, c and f only

package mem_pkg;

  // bus widths
  localparam int unsigned WORD_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned BE_W   = WORD_W / 8;

  // memory model depth in words
  localparam int unsigned RAM_WORDS   = 256;
  // wait cycles before busy drops
  localparam int unsigned RAM_LATENCY = 2;

  // derived widths for the memory model
  localparam int unsigned RAM_IDX_W = $clog2(RAM_WORDS);
  localparam int unsigned RAM_CNT_W = (RAM_LATENCY > 0) ? $clog2(RAM_LATENCY + 1) : 1;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [BE_W-1:0]      byte_en_t;
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;
  typedef logic [RAM_CNT_W-1:0] wait_cnt_t;

  // instruction fetch, read only
  typedef struct packed {
    logic  ren;
    addr_t addr;
  } iport_req_t;

  // data access, store data right aligned
  typedef struct packed {
    logic     ren;
    logic     wen;
    addr_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } dport_req_t;

  // request as seen by the memory, store data already on its lanes
  typedef struct packed {
    logic     ren;
    logic     wen;
    addr_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } mem_req_t;

  // arbiter states
  typedef enum logic [1:0] {
    IDLE,
    DATA_ACCESS,
    INSTR_ACCESS
  } arb_state_t;

endpackage

/* hw/mem_subsystem.sv */
// memory front end top level, arbiter in front of the wait-state memory
// instruction and data ports share the single memory port
// each access takes RAM_LATENCY+2 cycles from idle to completion
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                CLK,
  input  logic                nRST,
  input  mem_pkg::iport_req_t i_iport_req,
  input  mem_pkg::dport_req_t i_dport_req,
  output logic                o_iport_busy,
  output mem_pkg::word_t      o_iport_rdata,
  output logic                o_dport_busy,
  output mem_pkg::word_t      o_dport_rdata
);

  import mem_pkg::*;

  // arbiter to memory
  mem_req_t mem_req;

  // memory back to arbiter
  logic  mem_busy;
  word_t mem_rdata;

  // port arbitration and store lane alignment
  mem_arbiter u_arbiter (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_iport_req   (i_iport_req),
    .i_dport_req   (i_dport_req),
    .i_mem_busy    (mem_busy),
    .i_mem_rdata   (mem_rdata),
    .o_mem_req     (mem_req),
    .o_iport_busy  (o_iport_busy),
    .o_dport_busy  (o_dport_busy),
    .o_iport_rdata (o_iport_rdata),
    .o_dport_rdata (o_dport_rdata)
  );

  // shared word memory
  wait_state_ram u_ram (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_req   (mem_req),
    .o_busy  (mem_busy),
    .o_rdata (mem_rdata)
  );

endmodule

/* hw/wait_state_ram.sv */
// word memory model with a fixed number of wait states per access
// address bits above the depth alias, bits 1:0 are ignored
// contents are undefined until written, there is no init file
// a write lands at the clock edge that ends the completion cycle
`timescale 1ns/1ps

module wait_state_ram (
  input  logic              CLK,
  input  logic              nRST,
  input  mem_pkg::mem_req_t i_req,
  output logic              o_busy,
  output mem_pkg::word_t    o_rdata
);

  import mem_pkg::*;

  // storage
  word_t ram [RAM_WORDS];

  wait_cnt_t wait_cnt;
  ram_idx_t  word_idx;
  logic      req_active;
  logic      req_done;

  // word index from the byte address
  assign word_idx = i_req.addr[RAM_IDX_W+1:2];

  // any access held by the arbiter
  assign req_active = i_req.ren | i_req.wen;

  // last wait cycle reached
  assign req_done = req_active && (wait_cnt == wait_cnt_t'(RAM_LATENCY));

  // busy low for exactly one cycle per access
  assign o_busy = !req_done;

  // addressed word, sampled by the port while busy is low
  assign o_rdata = ram[word_idx];

  // wait counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!req_active || req_done) begin
      // restart for the next request
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // byte-enabled write on completion
  always_ff @(posedge CLK) begin
    if (req_done && i_req.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        // untouched lanes keep their old byte
        if (i_req.byte_en[b]) begin
          ram[word_idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the memory front end testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_mem_subsystem \
  -Mdir obj_dir \
  -f src.f

# a fatal stop returns nonzero, keep the output for the search below
sim_out=$(./obj_dir/Vtb_mem_subsystem 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

/* sim/tb_clock_gen.sv */
// clock and reset source for the testbench
// 10 ns period, nRST held low for the first 3 rising edges
// reset is released on a falling edge, away from the sampling edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  // free running clock
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // reset for 3 cycles
  initial begin
    nRST = 1'b0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

/* sim/tb_mem_subsystem.sv */
// self-checking testbench for the memory front end against a shadow memory
// every word is filled through the data port before any load or fetch
// inputs change on the falling edge, completions are sampled on the rising edge
// stops at the first mismatch, a watchdog bounds the run
`timescale 1ns/1ps

module tb_mem_subsystem;

  import mem_pkg::*;

  logic       CLK;
  logic       nRST;
  iport_req_t iport_req;
  dport_req_t dport_req;
  logic       iport_busy;
  word_t      iport_rdata;
  logic       dport_busy;
  word_t      dport_rdata;

  integer seed = 32'h99c0ad33;
  string  test_name = "reset";

  // expected memory contents
  word_t    shadow [RAM_WORDS];
  byte_en_t legal_be [7] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf};

  // completion bookkeeping written by the compare process only
  int unsigned cycle = 0;
  int unsigned dcount = 0;
  int unsigned icount = 0;
  int unsigned d_done_cycle = 0;
  int unsigned i_done_cycle = 0;

  // accesses in fill, random words, byte lanes, fetch, same-cycle and mixed stream
  int unsigned access_total = RAM_WORDS + 64 + 14 + 2 + 4 + 44;

  tb_clock_gen u_clock_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  mem_subsystem i_mem_subsystem (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_iport_req   (iport_req),
    .i_dport_req   (dport_req),
    .o_iport_busy  (iport_busy),
    .o_iport_rdata (iport_rdata),
    .o_dport_busy  (dport_busy),
    .o_dport_rdata (dport_rdata)
  );

  // memory word selected by a byte address with the upper bits aliased
  function automatic int word_index(input addr_t addr);
    return int'((addr >> 2) % RAM_WORDS);
  endfunction

  // initial contents mixing in every address bit
  function automatic word_t fill_word(input addr_t addr);
    return (addr * 32'h0100_0193) ^ 32'h5a5a_5a5a;
  endfunction

  // keep only the bits a right aligned store of this size carries
  function automatic word_t right_align_mask(input byte_en_t be);
    int lanes;
    lanes = 0;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) lanes++;
    end
    return (lanes >= BE_W) ? '1 : word_t'((33'h1 << (8 * lanes)) - 1);
  endfunction

  // reference store moving data up to the lowest enabled lane before the merge
  function automatic word_t merge_store(input word_t old, input word_t wdata,
                                        input byte_en_t be);
    word_t placed;
    word_t merged;
    int    low;
    low = 0;
    for (int b = BE_W - 1; b >= 0; b--) begin
      if (be[b]) low = b;
    end
    placed = wdata << (8 * low);
    merged = old;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) merged[8*b +: 8] = placed[8*b +: 8];
    end
    return merged;
  endfunction

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic check_dword(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAILED %s: data port expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_iword(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAILED %s: fetch expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: busy expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  // one data access where hold keeps the request up for a directly following one
  task automatic data_access(input logic wr, input addr_t addr, input word_t wdata,
                             input byte_en_t be, input logic hold);
    @(negedge CLK);
    dport_req.ren     = !wr;
    dport_req.wen     = wr;
    dport_req.addr    = addr;
    dport_req.wdata   = wdata;
    dport_req.byte_en = be;
    do @(posedge CLK); while (dport_busy);
    if (!hold) begin
      @(negedge CLK);
      dport_req = '0;
    end
  endtask

  // one fetch that may see at most one data completion while it waits
  task automatic fetch_word(input addr_t addr);
    int unsigned dcount_at_raise;
    @(negedge CLK);
    iport_req.ren  = 1'b1;
    iport_req.addr = addr;
    dcount_at_raise = dcount;
    do @(posedge CLK); while (iport_busy);
    if (dcount - dcount_at_raise > 1) begin
      report_error("fetch waited through more than one data access");
    end
    @(negedge CLK);
    iport_req = '0;
  endtask

  // compare process sampling every completion on the rising edge
  always @(posedge CLK) begin
    if (nRST) begin
      cycle++;
      if (!dport_busy) begin
        if (!(dport_req.ren || dport_req.wen)) begin
          report_error("data port completed with no request");
        end else if (dport_req.wen) begin
          shadow[word_index(dport_req.addr)] = merge_store(shadow[word_index(dport_req.addr)],
                                                           dport_req.wdata, dport_req.byte_en);
        end else begin
          check_dword(test_name, shadow[word_index(dport_req.addr)], dport_rdata);
        end
        dcount++;
        d_done_cycle = cycle;
      end
      if (!iport_busy) begin
        if (!iport_req.ren) begin
          report_error("instruction port completed with no request");
        end else begin
          check_iword(test_name, shadow[word_index(iport_req.addr)], iport_rdata);
        end
        icount++;
        i_done_cycle = cycle;
      end
    end
  end

  // watchdog with a generous budget per access
  initial begin
    repeat (access_total * 64 + 100) @(posedge CLK);
    $display("ERROR: watchdog expired, a request never completed");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    addr_t addr;
    word_t wdata;
    word_t rnd;
    int    idx;
    int    gaps [4];
    addr_t fetch_addr [4];

    iport_req = '0;
    dport_req = '0;
    @(posedge nRST);

    // quiet ports after reset
    test_name = "idle after reset";
    repeat (10) begin
      @(posedge CLK);
      check_busy(test_name, 1'b1, dport_busy);
      check_busy(test_name, 1'b1, iport_busy);
    end

    // known contents everywhere from stores chained back to back
    test_name = "memory fill";
    for (int i = 0; i < RAM_WORDS; i++) begin
      addr = addr_t'(i * 4);
      data_access(1'b1, addr, fill_word(addr), 4'hf, i != RAM_WORDS - 1);
    end

    // full word store then load
    test_name = "word store and load";
    repeat (32) begin
      addr  = addr_t'($random(seed)) & ~addr_t'(3);
      wdata = word_t'($random(seed));
      data_access(1'b1, addr, wdata, 4'hf, 1'b1);
      data_access(1'b0, addr, '0, 4'hf, 1'b0);
    end

    // byte and halfword stores that must leave the other lanes intact
    test_name = "partial stores";
    foreach (legal_be[k]) begin
      addr  = addr_t'($random(seed)) & ~addr_t'(3);
      wdata = word_t'($random(seed)) & right_align_mask(legal_be[k]);
      data_access(1'b1, addr, wdata, legal_be[k], 1'b1);
      data_access(1'b0, addr, '0, 4'hf, 1'b0);
    end

    // a fetch alone sees a word stored through the data port
    test_name = "lone fetch";
    addr = addr_t'($random(seed)) & ~addr_t'(3);
    data_access(1'b1, addr, 32'h1357_9bdf, 4'hf, 1'b0);
    fetch_word(addr);

    // both ports raised in one cycle with data going first
    test_name = "same cycle requests";
    for (int n = 0; n < 2; n++) begin
      addr  = addr_t'($random(seed)) & ~addr_t'(3);
      wdata = word_t'($random(seed));
      fetch_addr[0] = addr_t'($random(seed)) & ~addr_t'(3);
      fork
        data_access(n == 0, addr, wdata, 4'hf, 1'b0);
        fetch_word(fetch_addr[0]);
      join
      if (i_done_cycle <= d_done_cycle) report_error("fetch completed before the data access");
    end

    // held fetches against a stream of data accesses
    test_name = "fetch under data traffic";
    for (int f = 0; f < 4; f++) begin
      gaps[f]       = 1 + int'({$random(seed)} % 5);
      fetch_addr[f] = addr_t'($random(seed)) & ~addr_t'(3);
    end
    fork
      for (int d = 0; d < 40; d++) begin
        rnd   = word_t'($random(seed));
        idx   = int'({$random(seed)} % 7);
        addr  = addr_t'($random(seed)) & ~addr_t'(3);
        wdata = word_t'($random(seed)) & right_align_mask(legal_be[idx]);
        data_access(rnd[0], addr, wdata, rnd[0] ? legal_be[idx] : 4'hf, d != 39);
      end
      for (int f = 0; f < 4; f++) begin
        repeat (gaps[f]) @(negedge CLK);
        fetch_word(fetch_addr[f]);
      end
    join

    repeat (5) @(posedge CLK);
    $display("checked %0d data and %0d instruction completions", dcount, icount);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* src.f */
hw/mem_pkg.sv
hw/mem_arbiter.sv
hw/wait_state_ram.sv
hw/mem_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_mem_subsystem.sv
